/* logic/bus_pkg.sv */
package bus_pkg;
    typedef logic [15:0] data_word_t;

    // register driving the transfer bus
    typedef enum logic [3:0] {
        src_none = 4'd0,
        src_pc   = 4'd1,
        src_ar   = 4'd2,
        src_ir   = 4'd4,
        src_ac   = 4'd5,
        src_r    = 4'd6,
        src_r1   = 4'd7,
        src_r2   = 4'd8,
        src_r3   = 4'd9,
        src_r4   = 4'd10,
        src_dm   = 4'd12,
        src_im   = 4'd13
    } bus_src_e;

    localparam int en_width = 16;

    // bit positions in write_en, inc_en and clr_en
    localparam int en_pc        = 1;
    localparam int en_ar        = 2;
    localparam int en_ir        = 3;
    localparam int en_ac        = 4;
    localparam int en_r         = 5;
    localparam int en_r4        = 7;
    localparam int en_r3        = 8;
    localparam int en_r2        = 9;
    localparam int en_r1        = 10;
    localparam int en_dm        = 11;
    localparam int en_alu_to_ac = 12;
endpackage

/* logic/isa_pkg.sv */
package isa_pkg;
    import bus_pkg::*;

    localparam int instr_addr_bits = 10;

    // opcode value doubles as the entry state of the control FSM
    typedef enum logic [5:0] {
        op_ldac   = 6'd3,
        op_ldiac  = 6'd5,
        op_stac   = 6'd8,
        op_mvac   = 6'd9,
        op_mvacar = 6'd10,
        op_mvacr1 = 6'd11,
        op_mvacr2 = 6'd12,
        op_mvacr3 = 6'd13,
        op_mvacr4 = 6'd14,
        op_mvr1ac = 6'd15,
        op_mvr2ac = 6'd16,
        op_mvr3ac = 6'd17,
        op_mvr4ac = 6'd18,
        op_add    = 6'd19,
        op_mult   = 6'd20,
        op_lshift = 6'd21,
        op_sub    = 6'd22,
        op_inac   = 6'd23,
        op_jpnz   = 6'd24,
        op_nop    = 6'd28,
        op_clac   = 6'd30,
        op_endop  = 6'd31
    } opcode_e;

    typedef enum logic [2:0] {
        alu_pass   = 3'd0,
        alu_add    = 3'd1,
        alu_sub    = 3'd2,
        alu_mult   = 3'd3,
        alu_lshift = 3'd4
    } alu_op_e;

    typedef struct packed {
        logic [instr_addr_bits-1:0] addr;
        opcode_e                    opcode;
    } instr_fields_t;

    typedef union packed {
        data_word_t    raw;    // as seen on the bus
        instr_fields_t f;
    } instr_word_u;
endpackage

/* logic/alu.sv */
`timescale 1ns/1ps

module alu import bus_pkg::*; import isa_pkg::*; (
    input  alu_op_e    alu_op,
    input  data_word_t a,
    input  data_word_t b,
    output data_word_t result
);

    data_word_t product;

    assign product = a * b;    // low half only

    always_comb begin
        case (alu_op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_mult:   result = product;
            alu_lshift: result = {a[14:0], 1'b0};
            default:    result = a;
        endcase
    end

endmodule

/* logic/sync_ram.sv */
`timescale 1ns/1ps

module sync_ram import bus_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic [ADDR_WIDTH-1:0] addr_a,
    input  data_word_t            wdata_a,
    input  logic                  we_a,
    output data_word_t            rdata_a,
    input  logic [ADDR_WIDTH-1:0] addr_b,
    input  data_word_t            wdata_b,
    input  logic                  we_b,
    output data_word_t            rdata_b
);

    data_word_t mem [2**ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (we_a) mem[addr_a] <= wdata_a;
        if (we_b) mem[addr_b] <= wdata_b;
        rdata_a <= mem[addr_a];    // old data on a write
        rdata_b <= mem[addr_b];
    end

    a_no_write_clash: assert property (@(posedge clk)
        !(we_a && we_b && (addr_a == addr_b)));

endmodule

/* logic/control_unit.sv */
`timescale 1ns/1ps

module control_unit import bus_pkg::*; import isa_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  opcode_e             opcode,
    input  logic                z,
    output bus_src_e            bus_src,
    output logic [en_width-1:0] write_en,
    output logic [en_width-1:0] inc_en,
    output logic [en_width-1:0] clr_en,
    output alu_op_e             alu_op,
    output logic                end_process
);

    typedef enum logic [5:0] {
        st_start  = 6'd0,
        st_fetch1 = 6'd1,
        st_fetch2 = 6'd2,
        st_ldac1  = 6'd3,
        st_ldac2  = 6'd4,
        st_ldiac1 = 6'd5,
        st_ldiac2 = 6'd6,
        st_stac1  = 6'd8,
        st_mvac   = 6'd9,
        st_mvacar = 6'd10,
        st_mvacr1 = 6'd11,
        st_mvacr2 = 6'd12,
        st_mvacr3 = 6'd13,
        st_mvacr4 = 6'd14,
        st_mvr1ac = 6'd15,
        st_mvr2ac = 6'd16,
        st_mvr3ac = 6'd17,
        st_mvr4ac = 6'd18,
        st_add    = 6'd19,
        st_mult   = 6'd20,
        st_lshift = 6'd21,
        st_sub    = 6'd22,
        st_inac   = 6'd23,
        st_jpnz1  = 6'd24,
        st_jpnz2  = 6'd25,
        st_nop    = 6'd28,
        st_clac   = 6'd30,
        st_endop  = 6'd31,
        st_stac2  = 6'd36
    } state_e;

    state_e state, state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_start;
            end_process <= 1'b0;
        end else begin
            state       <= state_next;
            end_process <= (state == st_endop);
        end
    end

    always_comb begin
        bus_src    = src_none;
        write_en   = '0;
        inc_en     = '0;
        clr_en     = '0;
        alu_op     = alu_pass;
        state_next = st_fetch1;
        case (state)
            st_start: begin
                clr_en[en_pc] = 1'b1;
                clr_en[en_ac] = 1'b1;
            end
            st_fetch1: state_next = st_fetch2;    // IM read in flight
            st_fetch2: begin
                bus_src         = src_im;
                write_en[en_ir] = 1'b1;
                case (opcode)
                    op_ldac, op_ldiac, op_stac, op_mvac, op_mvacar,
                    op_mvacr1, op_mvacr2, op_mvacr3, op_mvacr4,
                    op_mvr1ac, op_mvr2ac, op_mvr3ac, op_mvr4ac,
                    op_add, op_mult, op_lshift, op_sub, op_inac,
                    op_jpnz, op_nop, op_clac, op_endop:
                        state_next = state_e'(opcode);
                    default: state_next = st_endop;
                endcase
            end
            st_ldac1: begin
                bus_src         = src_ac;    // indirect through AC
                write_en[en_ar] = 1'b1;
                state_next      = st_ldac2;
            end
            st_ldiac1: begin
                bus_src         = src_ir;
                write_en[en_ar] = 1'b1;
                state_next      = st_ldiac2;
            end
            st_ldac2, st_ldiac2: begin
                bus_src         = src_dm;
                write_en[en_ac] = 1'b1;
                inc_en[en_pc]   = 1'b1;
            end
            st_stac1: begin
                bus_src         = src_ir;
                write_en[en_ar] = 1'b1;
                state_next      = st_stac2;
            end
            st_stac2: begin
                write_en[en_dm] = 1'b1;
                inc_en[en_pc]   = 1'b1;
            end
            st_mvac, st_mvacar, st_mvacr1, st_mvacr2, st_mvacr3, st_mvacr4: begin
                bus_src       = src_ac;
                inc_en[en_pc] = 1'b1;
                case (state)
                    st_mvac:   write_en[en_r]  = 1'b1;
                    st_mvacar: write_en[en_ar] = 1'b1;
                    st_mvacr1: write_en[en_r1] = 1'b1;
                    st_mvacr2: write_en[en_r2] = 1'b1;
                    st_mvacr3: write_en[en_r3] = 1'b1;
                    default:   write_en[en_r4] = 1'b1;
                endcase
            end
            st_mvr1ac, st_mvr2ac, st_mvr3ac, st_mvr4ac: begin
                write_en[en_ac] = 1'b1;
                inc_en[en_pc]   = 1'b1;
                case (state)
                    st_mvr1ac: bus_src = src_r1;
                    st_mvr2ac: bus_src = src_r2;
                    st_mvr3ac: bus_src = src_r3;
                    default:   bus_src = src_r4;
                endcase
            end
            st_add, st_sub, st_mult, st_lshift: begin
                write_en[en_alu_to_ac] = 1'b1;
                inc_en[en_pc]          = 1'b1;
                case (state)
                    st_add:  alu_op = alu_add;
                    st_sub:  alu_op = alu_sub;
                    st_mult: alu_op = alu_mult;
                    default: alu_op = alu_lshift;
                endcase
            end
            st_inac: begin
                inc_en[en_ac] = 1'b1;
                inc_en[en_pc] = 1'b1;
            end
            st_clac: begin
                clr_en[en_ac] = 1'b1;
                inc_en[en_pc] = 1'b1;
            end
            st_nop: inc_en[en_pc] = 1'b1;
            st_jpnz1: begin
                if (z) begin
                    inc_en[en_pc] = 1'b1;    // fall through
                end else begin
                    state_next = st_jpnz2;
                end
            end
            st_jpnz2: begin
                bus_src         = src_ir;    // branch target from address field
                write_en[en_pc] = 1'b1;
            end
            default: state_next = st_endop;    // endop parks here
        endcase
    end

    a_one_bus_sink: assert property (@(posedge clk) disable iff (reset)
        $onehot0({write_en[en_r], write_en[en_r1], write_en[en_r2], write_en[en_r3],
                  write_en[en_r4], write_en[en_ar], write_en[en_dm]}));

endmodule

/* logic/datapath.sv */
`timescale 1ns/1ps

module datapath import bus_pkg::*; import isa_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  reset,
    input  bus_src_e              bus_src,
    input  logic [en_width-1:0]   write_en,
    input  logic [en_width-1:0]   inc_en,
    input  logic [en_width-1:0]   clr_en,
    input  alu_op_e               alu_op,
    input  data_word_t            im_rdata,
    input  data_word_t            dm_rdata,
    output logic [ADDR_WIDTH-1:0] im_addr,
    output logic [ADDR_WIDTH-1:0] dm_addr,
    output data_word_t            dm_wdata,
    output logic                  dm_we,
    output opcode_e               opcode,
    output logic                  z,
    output data_word_t            ac
);

    logic [ADDR_WIDTH-1:0]      pc, ar;
    logic [instr_addr_bits-1:0] addr_field;
    instr_word_u                ir_q, ir_d;
    data_word_t                 r, r1, r2, r3, r4;
    data_word_t                 bus, alu_result;

    always_comb begin
        case (bus_src)
            src_pc:  bus = data_word_t'(pc);
            src_ar:  bus = data_word_t'(ar);
            src_ir:  bus = ir_q.raw;
            src_ac:  bus = ac;
            src_r:   bus = r;
            src_r1:  bus = r1;
            src_r2:  bus = r2;
            src_r3:  bus = r3;
            src_r4:  bus = r4;
            src_dm:  bus = dm_rdata;
            src_im:  bus = im_rdata;
            default: bus = '0;
        endcase
    end

    // PC and AR take the address field when IR drives the bus
    assign addr_field = (bus_src == src_ir) ? ir_q.f.addr : bus[instr_addr_bits-1:0];

    // opcode seen by the FSM already during fetch2
    assign ir_d.raw = write_en[en_ir] ? bus : ir_q.raw;
    assign opcode   = ir_d.f.opcode;

    assign im_addr  = pc;
    assign dm_addr  = write_en[en_ar] ? addr_field[ADDR_WIDTH-1:0] : ar;    // AR bypass
    assign dm_wdata = ac;
    assign dm_we    = write_en[en_dm];
    assign z        = (ac == '0);

    alu alu0 (
        .alu_op (alu_op),
        .a      (ac),
        .b      (r),
        .result (alu_result)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            ac <= '0;
        end else begin
            if (clr_en[en_pc])
                pc <= '0;
            else if (write_en[en_pc])
                pc <= addr_field[ADDR_WIDTH-1:0];
            else if (inc_en[en_pc])
                pc <= pc + 1'b1;

            if (clr_en[en_ac])
                ac <= '0;
            else if (write_en[en_ac])
                ac <= bus;
            else if (write_en[en_alu_to_ac])
                ac <= alu_result;
            else if (inc_en[en_ac])
                ac <= ac + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en[en_ar]) ar <= addr_field[ADDR_WIDTH-1:0];
        if (write_en[en_ir]) ir_q <= ir_d;
        if (write_en[en_r])  r  <= bus;
        if (write_en[en_r1]) r1 <= bus;
        if (write_en[en_r2]) r2 <= bus;
        if (write_en[en_r3]) r3 <= bus;
        if (write_en[en_r4]) r4 <= bus;
    end

    a_ac_single_source: assert property (@(posedge clk) disable iff (reset)
        !(write_en[en_ac] && write_en[en_alu_to_ac]));

endmodule

/* logic/processor_top.sv */
`timescale 1ns/1ps

module processor_top import bus_pkg::*; import isa_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_we,
    input  logic                  load_sel,
    input  logic [ADDR_WIDTH-1:0] load_addr,
    input  data_word_t            load_data,
    input  logic [ADDR_WIDTH-1:0] peek_addr,
    output data_word_t            peek_data,
    output data_word_t            ac,
    output logic                  end_process
);

    bus_src_e              bus_src;
    logic [en_width-1:0]   write_en, inc_en, clr_en;
    alu_op_e               alu_op;
    opcode_e               opcode;
    logic                  z;
    logic [ADDR_WIDTH-1:0] im_addr, dm_addr;
    data_word_t            im_rdata, dm_rdata, dm_wdata;
    logic                  dm_we;

    control_unit cu0 (
        .clk(clk), .reset(reset), .opcode(opcode), .z(z),
        .bus_src(bus_src), .write_en(write_en), .inc_en(inc_en), .clr_en(clr_en),
        .alu_op(alu_op), .end_process(end_process)
    );

    datapath #(.ADDR_WIDTH(ADDR_WIDTH)) dp0 (
        .clk(clk), .reset(reset), .bus_src(bus_src), .write_en(write_en),
        .inc_en(inc_en), .clr_en(clr_en), .alu_op(alu_op),
        .im_rdata(im_rdata), .dm_rdata(dm_rdata), .im_addr(im_addr), .dm_addr(dm_addr),
        .dm_wdata(dm_wdata), .dm_we(dm_we), .opcode(opcode), .z(z), .ac(ac)
    );

    sync_ram #(.ADDR_WIDTH(ADDR_WIDTH)) im0 (    // program memory, read only in run
        .clk(clk), .addr_a(im_addr), .wdata_a('0), .we_a(1'b0), .rdata_a(im_rdata),
        .addr_b(load_addr), .wdata_b(load_data), .we_b(load_we & ~load_sel), .rdata_b()
    );

    sync_ram #(.ADDR_WIDTH(ADDR_WIDTH)) dm0 (
        .clk(clk), .addr_a(dm_addr), .wdata_a(dm_wdata), .we_a(dm_we), .rdata_a(dm_rdata),
        .addr_b(load_we ? load_addr : peek_addr), .wdata_b(load_data),
        .we_b(load_we & load_sel), .rdata_b(peek_data)
    );

endmodule

/* tb/tb_processor.sv */
`timescale 1ns/1ps

module tb_processor import bus_pkg::*; import isa_pkg::*; ();

    localparam int addr_width = 10;
    localparam int run_limit  = 2000;    // cycles per program

    logic                  clk;
    logic                  reset;
    logic                  load_we;
    logic                  load_sel;
    logic [addr_width-1:0] load_addr;
    data_word_t            load_data;
    logic [addr_width-1:0] peek_addr;
    data_word_t            peek_data;
    data_word_t            ac;
    logic                  end_process;

    int         error_count;
    int         timeout_count;
    data_word_t prog_q[$];
    int         data_addr_q[$];
    data_word_t data_val_q[$];

    processor_top #(.ADDR_WIDTH(addr_width)) dut0 (
        .clk(clk), .reset(reset), .load_we(load_we), .load_sel(load_sel),
        .load_addr(load_addr), .load_data(load_data), .peek_addr(peek_addr),
        .peek_data(peek_data), .ac(ac), .end_process(end_process)
    );

    always #20 clk = ~clk;

    task automatic check_word(string test_name, data_word_t expected, data_word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", test_name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_flag(string test_name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", test_name, expected, actual);
            error_count++;
        end
    endtask

    function automatic void new_image();
        prog_q.delete();
        data_addr_q.delete();
        data_val_q.delete();
    endfunction

    // address field above the opcode
    function automatic void add_instr(opcode_e op, int addr);
        logic [instr_addr_bits-1:0] field;
        field = addr[instr_addr_bits-1:0];
        prog_q.push_back({field, op});
    endfunction

    function automatic void add_data(int addr, data_word_t value);
        data_addr_q.push_back(addr);
        data_val_q.push_back(value);
    endfunction

    task automatic drive_load(logic sel, int addr, data_word_t value);
        @(posedge clk);
        #2;
        load_we   = 1'b1;
        load_sel  = sel;
        load_addr = addr[addr_width-1:0];
        load_data = value;
    endtask

    // reset, load both memories, release and wait for endop
    task automatic run_program(string test_name, output bit finished);
        int cycles;
        @(posedge clk);
        #2;
        reset = 1'b1;
        repeat (5) @(posedge clk);
        foreach (prog_q[i])
            drive_load(1'b0, i, prog_q[i]);
        foreach (data_addr_q[i])
            drive_load(1'b1, data_addr_q[i], data_val_q[i]);
        @(posedge clk);
        #2;
        load_we = 1'b0;
        reset   = 1'b0;
        cycles  = 0;
        while (end_process !== 1'b1 && cycles < run_limit) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        finished = (end_process === 1'b1);
        if (!finished) begin
            $display("%s: end_process never rose within %0d cycles", test_name, run_limit);
            timeout_count++;
        end
    endtask

    task automatic expect_dm(string test_name, int addr, data_word_t expected);
        @(posedge clk);
        #2;
        peek_addr = addr[addr_width-1:0];
        @(posedge clk);
        #2;    // one cycle read latency
        check_word($sformatf("%s dm[%0h]", test_name, addr), expected, peek_data);
    endtask

    task automatic test_load_store_move();
        int         src [4];
        data_word_t val [4];
        bit         finished;
        new_image();
        for (int i = 0; i < 4; i++) begin
            src[i] = 'h100 + ($urandom % 64) * 4 + i;    // distinct by low bits
            val[i] = data_word_t'($urandom);
            add_data(src[i], val[i]);
            add_instr(op_ldiac, src[i]);
            add_instr(opcode_e'(op_mvacr1 + i), 0);
        end
        add_instr(op_clac, 0);
        add_instr(op_stac, 'h200);
        for (int i = 0; i < 4; i++) begin
            add_instr(opcode_e'(op_mvr1ac + i), 0);
            add_instr(op_stac, 'h201 + i);
        end
        add_instr(op_mvr2ac, 0);
        add_instr(op_endop, 0);
        run_program("load_store_move", finished);
        if (finished) begin
            expect_dm("load_store_move", 'h200, '0);
            for (int i = 0; i < 4; i++)
                expect_dm("load_store_move", 'h201 + i, val[i]);
            check_word("load_store_move ac", val[1], ac);
        end
    endtask

    task automatic test_arithmetic();
        data_word_t a, b, c, d;
        data_word_t e [5];
        bit         finished;
        a = data_word_t'($urandom);
        b = data_word_t'($urandom);
        c = data_word_t'($urandom);
        d = data_word_t'($urandom);
        e[0] = b + a;
        e[1] = c - e[0];
        e[2] = e[1] << 1;
        e[3] = e[2] + 1'b1;
        e[4] = d * e[3];    // low 16 bits
        new_image();
        add_data('h10, a);
        add_data('h11, b);
        add_data('h12, c);
        add_data('h13, d);
        add_instr(op_ldiac, 'h10);
        add_instr(op_mvac, 0);
        add_instr(op_ldiac, 'h11);
        add_instr(op_add, 0);
        add_instr(op_stac, 'h20);
        add_instr(op_mvac, 0);
        add_instr(op_ldiac, 'h12);
        add_instr(op_sub, 0);
        add_instr(op_stac, 'h21);
        add_instr(op_lshift, 0);
        add_instr(op_stac, 'h22);
        add_instr(op_inac, 0);
        add_instr(op_stac, 'h23);
        add_instr(op_mvac, 0);
        add_instr(op_ldiac, 'h13);
        add_instr(op_mult, 0);
        add_instr(op_stac, 'h24);
        add_instr(op_endop, 0);
        run_program("arithmetic", finished);
        if (finished) begin
            for (int i = 0; i < 5; i++)
                expect_dm("arithmetic", 'h20 + i, e[i]);
            check_word("arithmetic ac", e[4], ac);
        end
    endtask

    task automatic test_countdown();
        data_word_t n;
        bit         finished;
        n = data_word_t'(1 + $urandom % 10);
        new_image();
        add_data('h40, 16'd1);
        add_data('h41, n);
        add_data('h42, '0);
        add_instr(op_ldiac, 'h40);
        add_instr(op_mvac, 0);    // R holds the step
        add_instr(op_ldiac, 'h41);
        add_instr(op_mvacr1, 0);    // loop top at 3
        add_instr(op_ldiac, 'h42);
        add_instr(op_inac, 0);
        add_instr(op_stac, 'h42);
        add_instr(op_mvr1ac, 0);
        add_instr(op_sub, 0);
        add_instr(op_jpnz, 3);
        add_instr(op_endop, 0);
        run_program("countdown", finished);
        if (finished) begin
            expect_dm("countdown", 'h42, n);
            check_word("countdown ac", '0, ac);
        end
    endtask

    task automatic test_indirect();
        int         p, q;
        data_word_t v, w;
        bit         finished;
        p = 'h80 + $urandom % 64;
        q = 'h240 + ($urandom % 32) * 2;
        v = data_word_t'($urandom);
        w = data_word_t'($urandom);
        new_image();
        add_data(p, data_word_t'(q));    // pointer
        add_data(q, v);
        add_data(q + 1, w);
        add_instr(op_ldiac, p);
        add_instr(op_ldac, 0);
        add_instr(op_stac, 'h300);
        add_instr(op_ldiac, p);
        add_instr(op_inac, 0);
        add_instr(op_mvacar, 0);
        add_instr(op_ldac, 0);
        add_instr(op_stac, 'h301);
        add_instr(op_endop, 0);
        run_program("indirect", finished);
        if (finished) begin
            expect_dm("indirect", 'h300, v);
            expect_dm("indirect", 'h301, w);
            check_word("indirect ac", w, ac);
        end
    endtask

    task automatic test_end_and_reset();
        data_word_t x;
        data_word_t expected;
        bit         finished;
        x = data_word_t'($urandom);
        expected = x + 1'b1;
        new_image();
        add_data('h50, x);
        add_instr(op_ldiac, 'h50);
        add_instr(op_inac, 0);
        add_instr(op_endop, 0);
        run_program("end_and_reset", finished);
        if (finished) begin
            check_word("end_and_reset ac", expected, ac);
            for (int i = 0; i < 20; i++) begin
                @(posedge clk);
                #2;
                check_flag("end_and_reset hold end_process", 1'b1, end_process);
                check_word("end_and_reset hold ac", expected, ac);
            end
            reset = 1'b1;
            repeat (5) @(posedge clk);
            #2;
            check_flag("end_and_reset end_process after reset", 1'b0, end_process);
            check_word("end_and_reset ac after reset", '0, ac);
        end
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        load_we       = 1'b0;
        load_sel      = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        peek_addr     = '0;
        error_count   = 0;
        timeout_count = 0;
        void'($urandom(56040));
        test_load_store_move();
        if (timeout_count == 0)
            test_arithmetic();
        if (timeout_count == 0)
            test_countdown();
        if (timeout_count == 0)
            test_indirect();
        if (timeout_count == 0)
            test_end_and_reset();
        $display("errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* project.f */
logic/bus_pkg.sv
logic/isa_pkg.sv
logic/alu.sv
logic/sync_ram.sv
logic/control_unit.sv
logic/datapath.sv
logic/processor_top.sv
tb/tb_processor.sv

/* Bender.yml */
package:
  name: processor

sources:
  - logic/bus_pkg.sv
  - logic/isa_pkg.sv
  - logic/alu.sv
  - logic/sync_ram.sv
  - logic/control_unit.sv
  - logic/datapath.sv
  - logic/processor_top.sv
  - target: test
    files:
      - tb/tb_processor.sv
